//--- verilog.f
common/adc_data_pkg.sv
common/adc_cfg_pkg.sv
hw/adc_reg_block.sv
hw/adc_front_end.sv
capture/capture_trigger.sv
capture/capture_stream.sv
hw/openadc_top.sv
dv/tb_openadc_top.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -Wno-fatal -f verilog.f \
      --top-module tb_openadc_top -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -q '^>>> PASS$' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- dv/tb_openadc_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_openadc_top;

   // about 2000 cycles of tests plus margin
   localparam int CYCLE_LIMIT = 6000;

   logic                       ADC_clk_sample;
   logic                       reset;
   adc_data_pkg::sample_t      adc_data;
   logic                       trigger;
   adc_cfg_pkg::reg_addr_t     reg_addr;
   logic [7:0]                 reg_wdata;
   logic                       reg_write;
   logic                       reg_read;
   logic [7:0]                 reg_rdata;
   adc_data_pkg::sample_beat_t stream;
   logic                       stream_valid;
   logic                       stream_ready;
   logic                       armed;
   logic                       capture_active;
   logic                       trigger_adc;
   logic                       amp_gain;

   integer                     seed;
   logic [31:0]                rnd;
   logic                       rand_adc_en;
   logic                       rand_ready_en;
   int                         cycles = 0;
   int                         err_value = 0;
   int                         err_other = 0;
   adc_data_pkg::sample_beat_t beat_q[$];
   int                         active_cycles;
   int                         drops;
   int                         adc_pulses;
   adc_data_pkg::sample_t      cur_level;
   adc_data_pkg::sample_t      adc_hist[3];
   logic                       prev_valid = 1'b0;
   logic                       prev_ready = 1'b0;
   adc_data_pkg::sample_beat_t prev_stream;

   openadc_top i_openadc_top (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .adc_data_i       (adc_data),
      .trigger_i        (trigger),
      .reg_addr_i       (reg_addr),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .reg_read_i       (reg_read),
      .reg_rdata_o      (reg_rdata),
      .stream_o         (stream),
      .stream_valid_o   (stream_valid),
      .stream_ready_i   (stream_ready),
      .armed_o          (armed),
      .capture_active_o (capture_active),
      .trigger_adc_o    (trigger_adc),
      .amp_gain_o       (amp_gain)
   );

   always #20 ADC_clk_sample = ~ADC_clk_sample;

   always @(posedge ADC_clk_sample) cycles++;

   initial begin
      wait (cycles >= CYCLE_LIMIT);
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
   end

   // random adc data and ready 2 ns after the edge
   always @(posedge ADC_clk_sample) begin
      #2;
      if (rand_adc_en) begin
         rnd = $random(seed);
         adc_data = rnd[11:0];
      end
      if (rand_ready_en) begin
         rnd = $random(seed);
         stream_ready = rnd[0];
      end
   end

   assert property (@(posedge ADC_clk_sample) disable iff (reset) trigger_adc |=> !trigger_adc)
      else begin
         $display("trigger_adc_o stayed high for more than one cycle");
         err_other++;
      end

   function automatic logic level_hit(input adc_data_pkg::sample_t s,
                                      input adc_data_pkg::sample_t lvl);
      if (lvl[adc_data_pkg::SAMPLE_W-1])
         return s > lvl;
      return s < lvl;
   endfunction

   // mid-cycle monitor where all inputs have settled
   always @(negedge ADC_clk_sample) begin
      if (!reset) begin
         if (prev_valid && !prev_ready) begin
            assert (stream_valid && stream == prev_stream) else begin
               $display("[FAIL] stream_o under stall: got %h expected %h", stream, prev_stream);
               err_value++;
            end
         end
         if (stream_valid && stream_ready)
            beat_q.push_back(stream);
         if (capture_active) begin
            active_cycles++;
            if (stream_valid && !stream_ready)
               drops++;   // with offset 0 active means a beat is offered
         end
         if (trigger_adc) begin
            adc_pulses++;
            if (armed) begin   // level is settled while armed
               assert (level_hit(adc_hist[2], cur_level)) else begin
                  $display("[FAIL] trigger_adc_o: sample %h level %h", adc_hist[2], cur_level);
                  err_value++;
               end
            end
         end
         adc_hist[2] = adc_hist[1];   // 2 resample stages plus the trigger register
         adc_hist[1] = adc_hist[0];
         adc_hist[0] = adc_data;
         prev_valid  = stream_valid;
         prev_ready  = stream_ready;
         prev_stream = stream;
      end
   end

   task automatic step();
      @(posedge ADC_clk_sample);
      #2;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got == exp) else begin
         $display("[FAIL] %s: got %h expected %h", name, got, exp);
         err_value++;
      end
   endtask

   task automatic write_reg(input adc_cfg_pkg::reg_addr_t addr, input logic [7:0] data);
      reg_addr  = addr;
      reg_wdata = data;
      reg_write = 1'b1;
      step();
      reg_write = 1'b0;
   endtask

   task automatic read_check(input adc_cfg_pkg::reg_addr_t addr, input logic [7:0] exp);
      reg_addr = addr;
      reg_read = 1'b1;
      step();
      reg_read = 1'b0;
      check_value("reg_rdata_o", {24'd0, reg_rdata}, {24'd0, exp});
   endtask

   function automatic logic [7:0] settings_byte(input logic mode, input logic wait_en,
                                                input logic src, input logic arm,
                                                input logic now);
      logic [7:0] b;
      b = '0;
      b[adc_cfg_pkg::SET_TRIG_MODE] = mode;
      b[adc_cfg_pkg::SET_TRIG_WAIT] = wait_en;
      b[adc_cfg_pkg::SET_SRC_ADC]   = src;
      b[adc_cfg_pkg::SET_ARM]       = arm;
      b[adc_cfg_pkg::SET_TRIG_NOW]  = now;
      return b;
   endfunction

   function automatic logic [7:0] status_byte(input logic arm_b, input logic idle_b,
                                              input logic pin, input logic ovf);
      logic [7:0] b;
      b = '0;
      b[adc_cfg_pkg::STAT_ARMED]    = arm_b;
      b[adc_cfg_pkg::STAT_IDLE]     = idle_b;
      b[adc_cfg_pkg::STAT_TRIG_PIN] = pin;
      b[adc_cfg_pkg::STAT_OVERFLOW] = ovf;
      return b;
   endfunction

   task automatic setup_capture(input adc_data_pkg::sample_t level, input logic [7:0] offset,
                                input logic [15:0] len);
      write_reg(adc_cfg_pkg::REG_TRIG_LEVEL_LO, level[7:0]);
      write_reg(adc_cfg_pkg::REG_TRIG_LEVEL_HI, {4'd0, level[11:8]});
      write_reg(adc_cfg_pkg::REG_OFFSET, offset);
      write_reg(adc_cfg_pkg::REG_LENGTH_LO, len[7:0]);
      write_reg(adc_cfg_pkg::REG_LENGTH_HI, len[15:8]);
      cur_level = level;
   endtask

   task automatic clear_stats();
      beat_q.delete();
      active_cycles = 0;
      drops         = 0;
      adc_pulses    = 0;
   endtask

   // returns once the trigger unit is idle and the output has drained
   task automatic wait_capture_done();
      step();
      while (armed || capture_active)
         step();
      repeat (4) step();   // output register drains
   endtask

   task automatic check_counter_beats(input int len);
      int                    i;
      adc_data_pkg::sample_t exp_data;
      check_value("stream_o beat count", beat_q.size(), len);
      for (i = 0; i < beat_q.size(); i++) begin
         if (i > 0) begin
            exp_data = beat_q[i-1].data + 12'd1;
            check_value("stream_o.data", {20'd0, beat_q[i].data}, {20'd0, exp_data});
         end
         check_value("stream_o.last", {31'd0, beat_q[i].last},
                     {31'd0, (i == beat_q.size() - 1)});
      end
   endtask

   initial begin
      adc_data_pkg::sample_t levels[4];
      logic [7:0]            gains[5];
      int                    run;
      int                    high_cnt;
      seed           = 32'haa33_09be;
      levels         = '{12'hc00, 12'h300, 12'ha00, 12'h500};
      gains          = '{8'd0, 8'd1, 8'd37, 8'd128, 8'd255};
      ADC_clk_sample = 1'b0;
      reset          = 1'b1;
      adc_data       = '0;
      trigger        = 1'b0;
      reg_addr       = adc_cfg_pkg::REG_STATUS;
      reg_wdata      = '0;
      reg_write      = 1'b0;
      reg_read       = 1'b0;
      stream_ready   = 1'b1;
      rand_adc_en    = 1'b0;
      rand_ready_en  = 1'b0;
      cur_level      = '0;
      clear_stats();
      repeat (3) @(posedge ADC_clk_sample);
      #2;
      reset = 1'b0;

      check_value("stream_valid_o", {31'd0, stream_valid}, 32'd0);
      check_value("armed_o", {31'd0, armed}, 32'd0);
      read_check(adc_cfg_pkg::REG_STATUS, status_byte(0, 1, 0, 0));

      // register readback
      write_reg(adc_cfg_pkg::REG_GAIN, 8'h5a);
      setup_capture(12'hca5, 8'h33, 16'h0112);
      write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 1, 1, 0, 0));
      read_check(adc_cfg_pkg::REG_GAIN, 8'h5a);
      read_check(adc_cfg_pkg::REG_TRIG_LEVEL_LO, 8'ha5);
      read_check(adc_cfg_pkg::REG_TRIG_LEVEL_HI, 8'h0c);
      read_check(adc_cfg_pkg::REG_OFFSET, 8'h33);
      read_check(adc_cfg_pkg::REG_LENGTH_LO, 8'h12);
      read_check(adc_cfg_pkg::REG_LENGTH_HI, 8'h01);
      read_check(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 1, 1, 0, 0));
      read_check(adc_cfg_pkg::reg_addr_t'(8'h20), 8'h00);

      // counter source, software trigger, ready high
      setup_capture(12'h000, 8'd3, 16'd20);
      write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 0, 1, 0));
      read_check(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 0, 0, 0));
      read_check(adc_cfg_pkg::REG_STATUS, status_byte(1, 1, 0, 0));
      clear_stats();
      write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 0, 0, 1));
      wait_capture_done();
      check_counter_beats(20);
      check_value("capture_active_o cycles", active_cycles, 23);
      read_check(adc_cfg_pkg::REG_STATUS, status_byte(0, 1, 0, 0));

      // wait mode with the trigger already active at arm
      setup_capture(12'h000, 8'd0, 16'd16);
      trigger = 1'b1;
      clear_stats();
      write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 1, 0, 1, 0));
      repeat (10) step();
      check_value("stream_o beat count", beat_q.size(), 0);
      read_check(adc_cfg_pkg::REG_STATUS, status_byte(1, 1, 1, 0));
      trigger = 1'b0;
      repeat (3) step();
      check_value("capture_active_o", {31'd0, capture_active}, 32'd0);
      trigger = 1'b1;
      wait_capture_done();
      check_counter_beats(16);

      // without wait the capture starts right after the arm
      clear_stats();
      write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 0, 1, 0));
      repeat (2) step();
      check_value("capture_active_o", {31'd0, capture_active}, 32'd1);
      wait_capture_done();
      check_counter_beats(16);

      // active low trigger with the pin high as inactive
      clear_stats();
      write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(0, 0, 0, 1, 0));
      repeat (10) step();
      check_value("armed_o", {31'd0, armed}, 32'd1);
      check_value("capture_active_o", {31'd0, capture_active}, 32'd0);
      trigger = 1'b0;
      wait_capture_done();
      check_counter_beats(16);

      // adc level trigger on random data
      rand_adc_en = 1'b1;
      write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 1, 0, 0));
      for (run = 0; run < 4; run++) begin
         setup_capture(levels[run], 8'd0, 16'd8);
         repeat (64) step();   // a one-shot left from an earlier arm fires here
         clear_stats();
         write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 1, 1, 0));
         wait_capture_done();
         check_value("trigger_adc_o pulses", adc_pulses, 1);
         check_value("stream_o beat count", beat_q.size(), 8);
      end
      rand_adc_en = 1'b0;

      // back-pressure with overflow cleared by each new arm
      for (run = 0; run < 2; run++) begin
         setup_capture(12'h000, 8'd0, 16'd40);
         write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 0, 1, 0));
         step();
         read_check(adc_cfg_pkg::REG_STATUS, status_byte(1, 1, 0, 0));
         clear_stats();
         rand_ready_en = 1'b1;
         write_reg(adc_cfg_pkg::REG_SETTINGS, settings_byte(1, 0, 0, 0, 1));
         wait_capture_done();
         rand_ready_en = 1'b0;
         stream_ready  = 1'b1;
         repeat (3) step();
         check_value("stream_o beats plus drops", beat_q.size() + drops, 40);
         read_check(adc_cfg_pkg::REG_STATUS, status_byte(0, 1, 0, drops != 0));
      end

      // pwm gain over a 256 cycle window
      for (run = 0; run < 5; run++) begin
         write_reg(adc_cfg_pkg::REG_GAIN, gains[run]);
         step();
         high_cnt = 0;
         repeat (256) begin
            step();
            if (amp_gain)
               high_cnt++;
         end
         check_value("amp_gain_o high cycles", high_cnt, {24'd0, gains[run]});
      end

      $display("errors: %0d wrong values, %0d other", err_value, err_other);
      if (err_value + err_other == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/openadc_top.sv
`timescale 1ns/10ps
`default_nettype none

module openadc_top (
   input  wire logic                               ADC_clk_sample,
   input  wire logic                               reset,
   input  wire adc_data_pkg::sample_t              adc_data_i,
   input  wire logic                               trigger_i,
   input  wire adc_cfg_pkg::reg_addr_t             reg_addr_i,
   input  wire logic [adc_cfg_pkg::REG_DATA_W-1:0] reg_wdata_i,
   input  wire logic                               reg_write_i,
   input  wire logic                               reg_read_i,
   output logic [adc_cfg_pkg::REG_DATA_W-1:0]      reg_rdata_o,
   output adc_data_pkg::sample_beat_t              stream_o,
   output logic                                    stream_valid_o,
   input  wire logic                               stream_ready_i,
   output logic                                    armed_o,
   output logic                                    capture_active_o,
   output logic                                    trigger_adc_o,
   output logic                                    amp_gain_o
);

   adc_cfg_pkg::capture_cfg_t cfg;
   adc_data_pkg::sample_t     sample;
   logic                      arm_cmd;
   logic                      trig_now_cmd;
   logic                      clear_overflow;
   logic                      src_adc;
   logic [7:0]                gain;
   logic                      capture_en;
   logic                      capture_last;
   logic                      overflow;

   adc_reg_block i_adc_reg_block (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .reg_addr_i       (reg_addr_i),
      .reg_wdata_i      (reg_wdata_i),
      .reg_write_i      (reg_write_i),
      .reg_read_i       (reg_read_i),
      .reg_rdata_o      (reg_rdata_o),
      .armed_i          (armed_o),
      .capture_active_i (capture_active_o),
      .trigger_i        (trigger_i),
      .overflow_i       (overflow),
      .cfg_o            (cfg),
      .arm_cmd_o        (arm_cmd),
      .trig_now_cmd_o   (trig_now_cmd),
      .clear_overflow_o (clear_overflow),
      .src_adc_o        (src_adc),
      .gain_o           (gain)
   );

   adc_front_end i_adc_front_end (
      .ADC_clk_sample (ADC_clk_sample),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .src_adc_i      (src_adc),
      .gain_i         (gain),
      .sample_o       (sample),
      .amp_gain_o     (amp_gain_o)
   );

   capture_trigger i_capture_trigger (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .cfg_i            (cfg),
      .arm_cmd_i        (arm_cmd),
      .trig_now_cmd_i   (trig_now_cmd),
      .trigger_i        (trigger_i),
      .sample_i         (sample),
      .armed_o          (armed_o),
      .capture_active_o (capture_active_o),
      .trigger_adc_o    (trigger_adc_o),
      .capture_en_o     (capture_en),
      .capture_last_o   (capture_last)
   );

   capture_stream i_capture_stream (
      .ADC_clk_sample   (ADC_clk_sample),
      .reset            (reset),
      .sample_i         (sample),
      .capture_en_i     (capture_en),
      .capture_last_i   (capture_last),
      .clear_overflow_i (clear_overflow),
      .stream_ready_i   (stream_ready_i),
      .stream_o         (stream_o),
      .stream_valid_o   (stream_valid_o),
      .overflow_o       (overflow)
   );

endmodule

`default_nettype wire

//--- capture/capture_stream.sv
`timescale 1ns/10ps
`default_nettype none

module capture_stream (
   input  wire logic                  ADC_clk_sample,
   input  wire logic                  reset,
   input  wire adc_data_pkg::sample_t sample_i,
   input  wire logic                  capture_en_i,
   input  wire logic                  capture_last_i,
   input  wire logic                  clear_overflow_i,
   input  wire logic                  stream_ready_i,
   output adc_data_pkg::sample_beat_t stream_o,
   output logic                       stream_valid_o,
   output logic                       overflow_o
);

   logic load;
   logic drop;

   // register free, or emptied by the consumer this cycle
   assign load = capture_en_i && (!stream_valid_o || stream_ready_i);
   assign drop = capture_en_i && stream_valid_o && !stream_ready_i;

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         stream_valid_o <= 1'b0;
         overflow_o     <= 1'b0;
      end else begin
         if (load)
            stream_valid_o <= 1'b1;
         else if (stream_ready_i)
            stream_valid_o <= 1'b0;

         if (clear_overflow_i)
            overflow_o <= 1'b0;
         else if (drop)
            overflow_o <= 1'b1;   // sticky until re-armed
      end
   end

   // payload only moves on a load, so it holds while stalled
   always_ff @(posedge ADC_clk_sample) begin
      if (load) begin
         stream_o.data <= sample_i;
         stream_o.last <= capture_last_i;
      end
   end

endmodule

`default_nettype wire

//--- capture/capture_trigger.sv
`timescale 1ns/10ps
`default_nettype none

module capture_trigger (
   input  wire logic                      ADC_clk_sample,
   input  wire logic                      reset,
   input  wire adc_cfg_pkg::capture_cfg_t cfg_i,
   input  wire logic                      arm_cmd_i,
   input  wire logic                      trig_now_cmd_i,
   input  wire logic                      trigger_i,
   input  wire adc_data_pkg::sample_t     sample_i,
   output logic                           armed_o,
   output logic                           capture_active_o,
   output logic                           trigger_adc_o,
   output logic                           capture_en_o,
   output logic                           capture_last_o
);

   adc_data_pkg::capture_state_t state_q;
   adc_data_pkg::capture_state_t state_d;
   logic [15:0] cnt_q;    // shared by offset and length
   logic [15:0] cnt_d;
   logic        trig_active;
   logic        trig_hit;
   logic        in_armed_q;
   logic        adc_allowed_q;
   logic        adc_cmp;

   assign trig_active = (trigger_i == cfg_i.trig_mode);
   assign trig_hit    = trig_active | trig_now_cmd_i | trigger_adc_o;

   // msb of the level picks the direction of the compare
   assign adc_cmp = cfg_i.trig_level[adc_data_pkg::SAMPLE_W-1] ?
                    (sample_i > cfg_i.trig_level) : (sample_i < cfg_i.trig_level);

   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      case (state_q)
         adc_data_pkg::IDLE: begin
            if (arm_cmd_i)
               state_d = cfg_i.trig_wait ? adc_data_pkg::WAIT_INACTIVE : adc_data_pkg::ARMED;
         end
         adc_data_pkg::WAIT_INACTIVE: begin
            if (!trig_active)
               state_d = adc_data_pkg::ARMED;
         end
         adc_data_pkg::ARMED: begin
            if (trig_hit && cfg_i.offset != '0) begin
               state_d = adc_data_pkg::DELAY;
               cnt_d   = {8'd0, cfg_i.offset} - 16'd1;
            end else if (trig_hit) begin
               state_d = (cfg_i.length != '0) ? adc_data_pkg::CAPTURE : adc_data_pkg::IDLE;
               cnt_d   = cfg_i.length - 16'd1;
            end
         end
         adc_data_pkg::DELAY: begin
            if (cnt_q == '0) begin
               state_d = (cfg_i.length != '0) ? adc_data_pkg::CAPTURE : adc_data_pkg::IDLE;
               cnt_d   = cfg_i.length - 16'd1;
            end else begin
               cnt_d = cnt_q - 16'd1;
            end
         end
         adc_data_pkg::CAPTURE: begin
            if (cnt_q == '0)
               state_d = adc_data_pkg::IDLE;
            else
               cnt_d = cnt_q - 16'd1;
         end
         default: state_d = adc_data_pkg::IDLE;
      endcase
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         state_q       <= adc_data_pkg::IDLE;
         cnt_q         <= '0;
         in_armed_q    <= 1'b0;
         adc_allowed_q <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         state_q    <= state_d;
         cnt_q      <= cnt_d;
         in_armed_q <= (state_q == adc_data_pkg::ARMED);
         // one shot, allowed again only on the next entry into ARMED
         trigger_adc_o <= adc_allowed_q & adc_cmp;
         if (adc_allowed_q && adc_cmp)
            adc_allowed_q <= 1'b0;
         else if (state_q == adc_data_pkg::ARMED && !in_armed_q)
            adc_allowed_q <= 1'b1;
      end
   end

   assign armed_o = (state_q == adc_data_pkg::ARMED) ||
                    (state_q == adc_data_pkg::WAIT_INACTIVE);
   assign capture_active_o = (state_q == adc_data_pkg::DELAY) ||
                             (state_q == adc_data_pkg::CAPTURE);
   assign capture_en_o   = (state_q == adc_data_pkg::CAPTURE);
   assign capture_last_o = capture_en_o && (cnt_q == '0);

endmodule

`default_nettype wire

//--- hw/adc_front_end.sv
`timescale 1ns/10ps
`default_nettype none

module adc_front_end (
   input  wire logic                  ADC_clk_sample,
   input  wire logic                  reset,
   input  wire adc_data_pkg::sample_t adc_data_i,
   input  wire logic                  src_adc_i,
   input  wire logic [7:0]            gain_i,
   output adc_data_pkg::sample_t      sample_o,
   output logic                       amp_gain_o
);

   adc_data_pkg::sample_t test_cnt;
   adc_data_pkg::sample_t sample_pre;
   logic [8:0]            pwm_acc;   // bit 8 is the carry out

   // free-running test pattern
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         test_cnt <= '0;
      else
         test_cnt <= test_cnt + 1'b1;
   end

   // two resample stages, no reset on the data path
   always_ff @(posedge ADC_clk_sample) begin
      sample_pre <= src_adc_i ? adc_data_i : test_cnt;
      sample_o   <= sample_pre;
   end

   // carry of the running sum is high gain_i times per 256 cycles
   always_ff @(posedge ADC_clk_sample) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_i};
   end

   assign amp_gain_o = pwm_acc[8];

endmodule

`default_nettype wire

//--- hw/adc_reg_block.sv
`timescale 1ns/10ps
`default_nettype none

module adc_reg_block (
   input  wire logic                               ADC_clk_sample,
   input  wire logic                               reset,
   input  wire adc_cfg_pkg::reg_addr_t             reg_addr_i,
   input  wire logic [adc_cfg_pkg::REG_DATA_W-1:0] reg_wdata_i,
   input  wire logic                               reg_write_i,
   input  wire logic                               reg_read_i,
   output logic [adc_cfg_pkg::REG_DATA_W-1:0]      reg_rdata_o,
   input  wire logic                               armed_i,
   input  wire logic                               capture_active_i,
   input  wire logic                               trigger_i,
   input  wire logic                               overflow_i,
   output adc_cfg_pkg::capture_cfg_t               cfg_o,
   output logic                                    arm_cmd_o,
   output logic                                    trig_now_cmd_o,
   output logic                                    clear_overflow_o,
   output logic                                    src_adc_o,
   output logic [7:0]                              gain_o
);

   logic       trig_mode_q;
   logic       trig_wait_q;
   logic [7:0] level_lo_q;
   logic [3:0] level_hi_q;
   logic [7:0] offset_q;
   logic [7:0] length_lo_q;
   logic [7:0] length_hi_q;
   logic [7:0] settings_rd;
   logic [7:0] status;
   logic [7:0] rd_data;

   // command bits are not stored, they read back as 0
   always_comb begin
      settings_rd = '0;
      settings_rd[adc_cfg_pkg::SET_TRIG_MODE] = trig_mode_q;
      settings_rd[adc_cfg_pkg::SET_TRIG_WAIT] = trig_wait_q;
      settings_rd[adc_cfg_pkg::SET_SRC_ADC]   = src_adc_o;
   end

   always_comb begin
      status = '0;
      status[adc_cfg_pkg::STAT_ARMED]    = armed_i;
      status[adc_cfg_pkg::STAT_IDLE]     = ~capture_active_i;
      status[adc_cfg_pkg::STAT_TRIG_PIN] = trigger_i;
      status[adc_cfg_pkg::STAT_OVERFLOW] = overflow_i;
   end

   always_comb begin
      case (reg_addr_i)
         adc_cfg_pkg::REG_STATUS:        rd_data = status;
         adc_cfg_pkg::REG_SETTINGS:      rd_data = settings_rd;
         adc_cfg_pkg::REG_GAIN:          rd_data = gain_o;
         adc_cfg_pkg::REG_TRIG_LEVEL_LO: rd_data = level_lo_q;
         adc_cfg_pkg::REG_TRIG_LEVEL_HI: rd_data = {4'd0, level_hi_q};
         adc_cfg_pkg::REG_OFFSET:        rd_data = offset_q;
         adc_cfg_pkg::REG_LENGTH_LO:     rd_data = length_lo_q;
         adc_cfg_pkg::REG_LENGTH_HI:     rd_data = length_hi_q;
         default:                        rd_data = '0;   // unmapped
      endcase
   end

   always_ff @(posedge ADC_clk_sample) begin
      if (reset) begin
         trig_mode_q    <= 1'b0;
         trig_wait_q    <= 1'b0;
         src_adc_o      <= 1'b0;
         gain_o         <= '0;
         level_lo_q     <= '0;
         level_hi_q     <= '0;
         offset_q       <= '0;
         length_lo_q    <= '0;
         length_hi_q    <= '0;
         arm_cmd_o      <= 1'b0;
         trig_now_cmd_o <= 1'b0;
         reg_rdata_o    <= '0;
      end else begin
         arm_cmd_o      <= 1'b0;   // pulses last one cycle
         trig_now_cmd_o <= 1'b0;
         if (reg_write_i) begin
            case (reg_addr_i)
               adc_cfg_pkg::REG_SETTINGS: begin
                  trig_mode_q    <= reg_wdata_i[adc_cfg_pkg::SET_TRIG_MODE];
                  trig_wait_q    <= reg_wdata_i[adc_cfg_pkg::SET_TRIG_WAIT];
                  src_adc_o      <= reg_wdata_i[adc_cfg_pkg::SET_SRC_ADC];
                  arm_cmd_o      <= reg_wdata_i[adc_cfg_pkg::SET_ARM];
                  trig_now_cmd_o <= reg_wdata_i[adc_cfg_pkg::SET_TRIG_NOW];
               end
               adc_cfg_pkg::REG_GAIN:          gain_o      <= reg_wdata_i;
               adc_cfg_pkg::REG_TRIG_LEVEL_LO: level_lo_q  <= reg_wdata_i;
               adc_cfg_pkg::REG_TRIG_LEVEL_HI: level_hi_q  <= reg_wdata_i[3:0];
               adc_cfg_pkg::REG_OFFSET:        offset_q    <= reg_wdata_i;
               adc_cfg_pkg::REG_LENGTH_LO:     length_lo_q <= reg_wdata_i;
               adc_cfg_pkg::REG_LENGTH_HI:     length_hi_q <= reg_wdata_i;
               default: ;
            endcase
         end
         if (reg_read_i)
            reg_rdata_o <= rd_data;   // held until the next read
      end
   end

   assign clear_overflow_o = arm_cmd_o;   // a new arm starts a clean capture

   assign cfg_o.trig_mode  = trig_mode_q;
   assign cfg_o.trig_wait  = trig_wait_q;
   assign cfg_o.trig_level = {level_hi_q, level_lo_q};
   assign cfg_o.offset     = offset_q;
   assign cfg_o.length     = {length_hi_q, length_lo_q};

endmodule

`default_nettype wire

//--- common/adc_cfg_pkg.sv
`default_nettype none

package adc_cfg_pkg;

   localparam int unsigned REG_ADDR_W = 8;
   localparam int unsigned REG_DATA_W = 8;

   // byte-wide register map
   typedef enum logic [REG_ADDR_W-1:0] {
      REG_STATUS        = 8'h00,
      REG_SETTINGS      = 8'h01,
      REG_GAIN          = 8'h02,
      REG_TRIG_LEVEL_LO = 8'h03,
      REG_TRIG_LEVEL_HI = 8'h04,   // upper 4 bits of the level
      REG_OFFSET        = 8'h05,
      REG_LENGTH_LO     = 8'h06,
      REG_LENGTH_HI     = 8'h07
   } reg_addr_t;

   // REG_SETTINGS fields
   localparam int unsigned SET_ARM       = 0;   // self-clearing
   localparam int unsigned SET_TRIG_MODE = 1;   // 1 = trigger active high
   localparam int unsigned SET_TRIG_WAIT = 2;
   localparam int unsigned SET_SRC_ADC   = 3;   // 0 = test counter
   localparam int unsigned SET_TRIG_NOW  = 4;   // self-clearing

   // status byte fields
   localparam int unsigned STAT_ARMED    = 0;
   localparam int unsigned STAT_IDLE     = 1;
   localparam int unsigned STAT_TRIG_PIN = 2;
   localparam int unsigned STAT_OVERFLOW = 7;

   // everything the trigger unit needs from the registers
   typedef struct packed {
      logic                 trig_mode;
      logic                 trig_wait;
      adc_data_pkg::sample_t trig_level;
      logic [7:0]           offset;
      logic [15:0]          length;
   } capture_cfg_t;

endpackage

`default_nettype wire

//--- common/adc_data_pkg.sv
`default_nettype none

package adc_data_pkg;

   // width of one ADC conversion
   localparam int unsigned SAMPLE_W = 12;

   typedef logic [SAMPLE_W-1:0] sample_t;

   // one beat on the capture stream
   typedef struct packed {
      sample_t data;
      logic    last;    // final beat of a capture
   } sample_beat_t;

   // arm/trigger sequencing
   typedef enum logic [2:0] {
      IDLE          = 3'd0,
      WAIT_INACTIVE = 3'd1,   // armed, trigger must go inactive first
      ARMED         = 3'd2,
      DELAY         = 3'd3,   // post-trigger offset
      CAPTURE       = 3'd4
   } capture_state_t;

endpackage

`default_nettype wire
